//--- source/noc_pkg.sv
package noc_pkg;

  // ~~~~~~~~~~~~~~~~~~~~
  // network dimensions
  // ~~~~~~~~~~~~~~~~~~~~
  localparam int NUM_PORTS     = 2;
  localparam int PAYLOAD_W     = 32;
  localparam int FLIT_DATA_W   = 8;
  localparam int FLITS_PER_PKT = 4;
  localparam int BUF_DEPTH     = 4;

  localparam int PORT_ID_W = $clog2(NUM_PORTS);
  localparam int BUF_PTR_W = $clog2(BUF_DEPTH);

  // flit layout, msb first: tail, dest, src, data
  localparam int FLIT_W        = 1 + 2 * PORT_ID_W + FLIT_DATA_W;
  localparam int FLIT_TAIL     = FLIT_W - 1;
  localparam int FLIT_DEST_LSB = FLIT_DATA_W + PORT_ID_W;
  localparam int FLIT_SRC_LSB  = FLIT_DATA_W;

  // ~~~~~~~~~~~~~~~~~~~~
  // types
  // ~~~~~~~~~~~~~~~~~~~~
  typedef logic [PAYLOAD_W-1:0]                 payload_t;
  typedef logic [PORT_ID_W-1:0]                 port_id_t;
  typedef logic [FLIT_DATA_W-1:0]               flit_data_t;
  typedef logic [FLIT_W-1:0]                    flit_t;
  typedef logic [$clog2(FLITS_PER_PKT)-1:0]     flit_idx_t;
  // one extra bit so the count can hold BUF_DEPTH itself
  typedef logic [$clog2(BUF_DEPTH + 1)-1:0]     credit_t;

  typedef enum logic {
    IDLE,
    SEND
  } ser_state_t;

endpackage

//--- source/flit_serializer.sv
`timescale 1ns/1ps

module flit_serializer #(
  parameter noc_pkg::port_id_t SRC_ID = '0
) (
  input  logic              CLK_NOC,
  input  logic              rst_n,
  input  noc_pkg::payload_t s_tdata,
  input  noc_pkg::port_id_t s_tdest,
  input  logic              s_tvalid,
  output logic              s_tready,
  output noc_pkg::flit_t    flit,
  output logic              flit_valid,
  input  logic              flit_ready
);

  import noc_pkg::*;

  ser_state_t state;
  flit_idx_t  idx;
  payload_t   payload_q;
  port_id_t   dest_q;
  logic       last_slice;
  flit_data_t slice;

  assign last_slice = (idx == flit_idx_t'(FLITS_PER_PKT - 1));
  // slice 0 is the low byte and goes out first
  assign slice      = payload_q[idx * FLIT_DATA_W +: FLIT_DATA_W];

  assign s_tready   = (state == IDLE);
  assign flit_valid = (state == SEND);
  assign flit       = {last_slice, dest_q, SRC_ID, slice};

  always_ff @(posedge CLK_NOC) begin
    if (!rst_n) begin
      state <= IDLE;
      idx   <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (s_tvalid) begin
            state <= SEND;
            idx   <= '0;
          end
        end
        SEND: begin
          if (flit_ready) begin
            // index wraps back to zero after the tail
            idx <= idx + 1'b1;
            if (last_slice) begin
              state <= IDLE;
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // word capture
  always_ff @(posedge CLK_NOC) begin
    if (s_tvalid && s_tready) begin
      payload_q <= s_tdata;
      dest_q    <= s_tdest;
    end
  end

endmodule

//--- source/credit_counter.sv
`timescale 1ns/1ps

module credit_counter (
  input  logic CLK_NOC,
  input  logic rst_n,
  input  logic take,
  input  logic give,
  output logic credit_avail
);

  import noc_pkg::*;

  credit_t count;

  assign credit_avail = (count != '0);

  always_ff @(posedge CLK_NOC) begin
    if (!rst_n) begin
      count <= credit_t'(BUF_DEPTH);
    end else begin
      // take and give together cancel out
      case ({take, give})
        2'b10:   count <= count - 1'b1;
        2'b01:   count <= count + 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- source/packet_switch.sv
`timescale 1ns/1ps

module packet_switch (
  input  logic           CLK_NOC,
  input  logic           rst_n,
  input  noc_pkg::flit_t in_flit      [noc_pkg::NUM_PORTS],
  input  logic           in_valid     [noc_pkg::NUM_PORTS],
  output logic           in_ready     [noc_pkg::NUM_PORTS],
  input  logic           credit_avail [noc_pkg::NUM_PORTS],
  output noc_pkg::flit_t out_flit     [noc_pkg::NUM_PORTS],
  output logic           out_valid    [noc_pkg::NUM_PORTS]
);

  import noc_pkg::*;

  // per egress state
  logic     lock    [NUM_PORTS];
  port_id_t owner   [NUM_PORTS];
  port_id_t rr_last [NUM_PORTS];

  logic     gnt_valid [NUM_PORTS];
  port_id_t gnt_src   [NUM_PORTS];
  port_id_t in_dest   [NUM_PORTS];

  always_comb begin
    for (int s = 0; s < NUM_PORTS; s++) begin
      in_dest[s] = in_flit[s][FLIT_DEST_LSB +: PORT_ID_W];
    end

    for (int e = 0; e < NUM_PORTS; e++) begin
      gnt_valid[e] = 1'b0;
      gnt_src[e]   = owner[e];
      if (lock[e]) begin
        gnt_valid[e] = in_valid[owner[e]] && (in_dest[owner[e]] == port_id_t'(e));
      end else begin
        // walk backwards so the source right after rr_last wins
        for (int i = NUM_PORTS; i >= 1; i--) begin
          if (in_valid[port_id_t'(rr_last[e] + i)] &&
              in_dest[port_id_t'(rr_last[e] + i)] == port_id_t'(e)) begin
            gnt_valid[e] = 1'b1;
            gnt_src[e]   = port_id_t'(rr_last[e] + i);
          end
        end
      end
      out_valid[e] = gnt_valid[e] && credit_avail[e];
      out_flit[e]  = in_flit[gnt_src[e]];
    end

    for (int s = 0; s < NUM_PORTS; s++) begin
      in_ready[s] = out_valid[in_dest[s]] && (gnt_src[in_dest[s]] == port_id_t'(s));
    end
  end

  always_ff @(posedge CLK_NOC) begin
    if (!rst_n) begin
      for (int e = 0; e < NUM_PORTS; e++) begin
        lock[e]    <= 1'b0;
        owner[e]   <= '0;
        rr_last[e] <= '0;
      end
    end else begin
      for (int e = 0; e < NUM_PORTS; e++) begin
        if (out_valid[e]) begin
          if (!lock[e]) begin
            owner[e] <= gnt_src[e];
          end
          // hold the egress until the tail leaves
          lock[e] <= !out_flit[e][FLIT_TAIL];
          if (out_flit[e][FLIT_TAIL]) begin
            rr_last[e] <= gnt_src[e];
          end
        end
      end
    end
  end

endmodule

//--- source/egress_port.sv
`timescale 1ns/1ps

module egress_port (
  input  logic              CLK_NOC,
  input  logic              rst_n,
  input  logic              in_valid,
  input  noc_pkg::flit_t    in_flit,
  output logic              credit_return,
  output noc_pkg::payload_t m_tdata,
  output noc_pkg::port_id_t m_tid,
  output logic              m_tvalid,
  input  logic              m_tready
);

  import noc_pkg::*;

  flit_t                mem [BUF_DEPTH];
  logic [BUF_PTR_W-1:0] wr_ptr;
  logic [BUF_PTR_W-1:0] rd_ptr;
  credit_t              count;
  flit_t                head;
  logic                 pop;
  payload_t             asm_q;

  assign head = mem[rd_ptr];
  // a finished word blocks assembly until it is taken
  assign pop           = (count != '0) && (!m_tvalid || m_tready);
  assign credit_return = pop;
  assign m_tdata       = asm_q;

  // ~~~~~~~~~~~~~~~~~~~~
  // flit ring buffer
  // ~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge CLK_NOC) begin
    if (in_valid) begin
      mem[wr_ptr] <= in_flit;
    end
  end

  always_ff @(posedge CLK_NOC) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (in_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({in_valid, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // reassembly
  // ~~~~~~~~~~~~~~~~~~~~
  // bytes shift in from the top, slice 0 ends up lowest
  always_ff @(posedge CLK_NOC) begin
    if (pop) begin
      asm_q <= {head[FLIT_DATA_W-1:0], asm_q[PAYLOAD_W-1:FLIT_DATA_W]};
      if (head[FLIT_TAIL]) begin
        m_tid <= head[FLIT_SRC_LSB +: PORT_ID_W];
      end
    end
  end

  always_ff @(posedge CLK_NOC) begin
    if (!rst_n) begin
      m_tvalid <= 1'b0;
    end else if (pop && head[FLIT_TAIL]) begin
      m_tvalid <= 1'b1;
    end else if (m_tvalid && m_tready) begin
      m_tvalid <= 1'b0;
    end
  end

endmodule

//--- source/noc_stream_top.sv
`timescale 1ns/1ps

module noc_stream_top (
  input  logic              CLK_NOC,
  input  logic              rst_n,
  input  noc_pkg::payload_t s_tdata  [noc_pkg::NUM_PORTS],
  input  noc_pkg::port_id_t s_tdest  [noc_pkg::NUM_PORTS],
  input  logic              s_tvalid [noc_pkg::NUM_PORTS],
  output logic              s_tready [noc_pkg::NUM_PORTS],
  output noc_pkg::payload_t m_tdata  [noc_pkg::NUM_PORTS],
  output noc_pkg::port_id_t m_tid    [noc_pkg::NUM_PORTS],
  output logic              m_tvalid [noc_pkg::NUM_PORTS],
  input  logic              m_tready [noc_pkg::NUM_PORTS]
);

  import noc_pkg::*;

  flit_t flit          [NUM_PORTS];
  logic  flit_valid    [NUM_PORTS];
  logic  flit_ready    [NUM_PORTS];
  flit_t out_flit      [NUM_PORTS];
  logic  out_valid     [NUM_PORTS];
  logic  credit_avail  [NUM_PORTS];
  logic  credit_return [NUM_PORTS];

  packet_switch switch_i (
    .CLK_NOC      (CLK_NOC),
    .rst_n        (rst_n),
    .in_flit      (flit),
    .in_valid     (flit_valid),
    .in_ready     (flit_ready),
    .credit_avail (credit_avail),
    .out_flit     (out_flit),
    .out_valid    (out_valid)
  );

  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
    flit_serializer #(
      .SRC_ID (port_id_t'(p))
    ) ser_i (
      .CLK_NOC    (CLK_NOC),
      .rst_n      (rst_n),
      .s_tdata    (s_tdata[p]),
      .s_tdest    (s_tdest[p]),
      .s_tvalid   (s_tvalid[p]),
      .s_tready   (s_tready[p]),
      .flit       (flit[p]),
      .flit_valid (flit_valid[p]),
      .flit_ready (flit_ready[p])
    );

    credit_counter credit_i (
      .CLK_NOC      (CLK_NOC),
      .rst_n        (rst_n),
      .take         (out_valid[p]),
      .give         (credit_return[p]),
      .credit_avail (credit_avail[p])
    );

    egress_port egress_i (
      .CLK_NOC       (CLK_NOC),
      .rst_n         (rst_n),
      .in_valid      (out_valid[p]),
      .in_flit       (out_flit[p]),
      .credit_return (credit_return[p]),
      .m_tdata       (m_tdata[p]),
      .m_tid         (m_tid[p]),
      .m_tvalid      (m_tvalid[p]),
      .m_tready      (m_tready[p])
    );
  end

endmodule

//--- testbench/clock_gen.sv
`timescale 1ns/1ps

module clock_gen (
  output logic CLK_NOC
);

  // 100 ns period
  initial begin
    CLK_NOC = 1'b0;
    forever #50 CLK_NOC = ~CLK_NOC;
  end

endmodule

//--- testbench/noc_stream_sva.sv
`timescale 1ns/1ps

module noc_stream_sva (
  input logic           CLK_NOC,
  input logic           rst_n,
  input noc_pkg::flit_t in_flit       [noc_pkg::NUM_PORTS],
  input logic           in_valid      [noc_pkg::NUM_PORTS],
  input logic           in_ready      [noc_pkg::NUM_PORTS],
  input noc_pkg::flit_t out_flit      [noc_pkg::NUM_PORTS],
  input logic           out_valid     [noc_pkg::NUM_PORTS],
  input logic           credit_return [noc_pkg::NUM_PORTS]
);

  import noc_pkg::*;

  // flits sent to each egress and not yet handed back as credit
  int held [NUM_PORTS];

  always_ff @(posedge CLK_NOC) begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (!rst_n) begin
        held[p] <= 0;
      end else begin
        held[p] <= held[p] + int'(out_valid[p]) - int'(credit_return[p]);
      end
    end
  end

  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_chk
    a_credit: assert property (@(posedge CLK_NOC) disable iff (!rst_n)
      out_valid[p] |-> held[p] < BUF_DEPTH)
      else $error("egress %0d got a flit with no credit", p);

    // an offered flit holds until the switch takes it
    a_stable: assert property (@(posedge CLK_NOC) disable iff (!rst_n)
      in_valid[p] && !in_ready[p] |=> in_valid[p] && $stable(in_flit[p]))
      else $error("source %0d changed its flit before it moved", p);

    a_dest: assert property (@(posedge CLK_NOC) disable iff (!rst_n)
      out_valid[p] |-> out_flit[p][FLIT_DEST_LSB +: PORT_ID_W] == port_id_t'(p))
      else $error("egress %0d got a flit for another port", p);
  end

endmodule

bind noc_stream_top noc_stream_sva sva_i (
  .CLK_NOC       (CLK_NOC),
  .rst_n         (rst_n),
  .in_flit       (flit),
  .in_valid      (flit_valid),
  .in_ready      (flit_ready),
  .out_flit      (out_flit),
  .out_valid     (out_valid),
  .credit_return (credit_return)
);

//--- testbench/noc_stream_tb.sv
`timescale 1ns/1ps

module noc_stream_tb;

  import noc_pkg::*;

  localparam int MAX_PAT = 32;

  logic     CLK_NOC;
  logic     rst_n;
  payload_t s_tdata  [NUM_PORTS];
  port_id_t s_tdest  [NUM_PORTS];
  logic     s_tvalid [NUM_PORTS];
  logic     s_tready [NUM_PORTS];
  payload_t m_tdata  [NUM_PORTS];
  port_id_t m_tid    [NUM_PORTS];
  logic     m_tvalid [NUM_PORTS];
  logic     m_tready [NUM_PORTS];

  // pattern word: src [39:36], dest [35:32], payload [31:0]
  logic [39:0] pat_mem  [MAX_PAT];
  logic [39:0] exp_q    [NUM_PORTS][NUM_PORTS][$];
  int          src_line [NUM_PORTS][$];
  logic [39:0] entry;
  port_id_t    exp_src;
  int          n_pat;
  int          delivered;
  int          cycles;
  int          quiet;
  int          timeout_limit;
  int          last_accept [NUM_PORTS];
  logic        running;
  logic [31:0] rng;

  clock_gen clk_i (.CLK_NOC(CLK_NOC));

  noc_stream_top dut_i (.*);

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // all lines accepted, serializers idle, no word waiting at an output
  function automatic logic network_idle();
    logic idle;
    idle = 1'b1;
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (src_line[p].size() != 0 || s_tvalid[p] || !s_tready[p] || m_tvalid[p]) begin
        idle = 1'b0;
      end
    end
    return idle;
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // compare tasks
  // ~~~~~~~~~~~~~~~~~~~~
  task automatic check_payload(input payload_t got, input payload_t expected, input int port);
    if (got !== expected) begin
      fail_run($sformatf("ERR %0t: port %0d payload %h, expected %h",
                         $time, port, got, expected));
    end
  endtask

  task automatic check_port(input port_id_t got, input port_id_t expected, input string what);
    if (got !== expected) begin
      fail_run($sformatf("ERR %0t: %s is %0d, expected %0d", $time, what, got, expected));
    end
  endtask

  task automatic check_count(input int got, input int expected);
    if (got != expected) begin
      fail_run($sformatf("ERR %0t: %0d words delivered, expected %0d", $time, got, expected));
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // drive, monitor, timeout
  // ~~~~~~~~~~~~~~~~~~~~
  always @(posedge CLK_NOC) begin
    cycles <= cycles + 1;
    if (cycles >= timeout_limit) begin
      fail_run($sformatf("timeout after %0d cycles, only %0d of %0d words came out",
                         cycles, delivered, n_pat));
    end
    if (running) begin
      rng = xorshift32(rng);
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (s_tvalid[p] && s_tready[p]) begin
          if (cycles - last_accept[p] <= 4) begin
            fail_run($sformatf("port %0d accepted a second word too soon at %0t", p, $time));
          end
          last_accept[p] = cycles;
          src_line[p].delete(0);
          s_tvalid[p] <= 1'b0;
        end else if (!s_tvalid[p] && src_line[p].size() > 0 && rng[8 + p]) begin
          s_tdata[p]  <= pat_mem[src_line[p][0]][31:0];
          s_tdest[p]  <= port_id_t'(pat_mem[src_line[p][0]][35:32]);
          s_tvalid[p] <= 1'b1;
        end
        // ready about three cycles in four
        m_tready[p] <= (rng[p * 4 +: 2] != 2'b00);

        if (m_tvalid[p] && m_tready[p]) begin
          // source whose next word for this port carries this payload
          exp_src = m_tid[p];
          for (int s = 0; s < NUM_PORTS; s++) begin
            if (exp_q[s][p].size() > 0 && exp_q[s][p][0][31:0] == m_tdata[p]) begin
              exp_src = port_id_t'(s);
            end
          end
          check_port(m_tid[p], exp_src, "source id");
          if (exp_q[m_tid[p]][p].size() == 0) begin
            fail_run($sformatf("port %0d gave out %h from source %0d, which was never sent",
                               p, m_tdata[p], m_tid[p]));
          end
          entry = exp_q[m_tid[p]][p].pop_front();
          check_payload(m_tdata[p], entry[31:0], p);
          delivered = delivered + 1;
        end
      end
    end
  end

  initial begin
    rst_n     = 1'b0;
    running   = 1'b0;
    rng       = 32'haf34e4a1;
    cycles    = 0;
    delivered = 0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      s_tdata[p]     = '0;
      s_tdest[p]     = '0;
      s_tvalid[p]    = 1'b0;
      m_tready[p]    = 1'b1;
      last_accept[p] = -100;
    end
    // unused lines keep an out of range source
    for (int i = 0; i < MAX_PAT; i++) begin
      pat_mem[i] = {8'hff, 32'(i)};
    end
    $readmemh("testbench/noc_stream_patterns.hex", pat_mem);
    n_pat = 0;
    while (n_pat < MAX_PAT && pat_mem[n_pat][39:32] != 8'hff) begin
      src_line[port_id_t'(pat_mem[n_pat][39:36])].push_back(n_pat);
      exp_q[port_id_t'(pat_mem[n_pat][39:36])][port_id_t'(pat_mem[n_pat][35:32])]
        .push_back(pat_mem[n_pat]);
      n_pat++;
    end
    if (n_pat == 0) begin
      fail_run("no patterns could be read from testbench/noc_stream_patterns.hex");
    end
    timeout_limit = n_pat * 40 + 200;

    repeat (10) @(posedge CLK_NOC);
    rst_n <= 1'b1;

    // quiet ports right after reset
    repeat (8) begin
      @(negedge CLK_NOC);
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (m_tvalid[p] !== 1'b0 || s_tready[p] !== 1'b1) begin
          fail_run($sformatf("port %0d is not idle after reset", p));
        end
      end
    end

    @(posedge CLK_NOC);
    running <= 1'b1;
    // a buffered word reaches m_tvalid well within this many idle cycles
    quiet = 0;
    while (quiet < 2 * BUF_DEPTH) begin
      @(negedge CLK_NOC);
      if (network_idle()) begin
        quiet++;
      end else begin
        quiet = 0;
      end
    end
    check_count(delivered, n_pat);
    $display("Simulation passed");
    $finish;
  end

endmodule

//--- testbench/noc_stream_patterns.hex
// one word per line: source _ destination _ payload
// packed as src[39:36] dest[35:32] payload[31:0]
0_1_12345678
1_1_a5a5c3c3
0_1_0badf00d
1_1_deadbeef
0_1_01020304
1_1_fedcba98
0_0_cafe0001
1_0_0000ffff
0_1_80000001
1_1_7f7f7f7f
1_0_00112233
0_0_f0e1d2c3

//--- noc_stream.f
source/noc_pkg.sv
source/flit_serializer.sv
source/credit_counter.sv
source/packet_switch.sv
source/egress_port.sv
source/noc_stream_top.sv
testbench/clock_gen.sv
testbench/noc_stream_sva.sv
testbench/noc_stream_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= noc_stream_tb
FILELIST  ?= noc_stream.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary -j 0 $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then exit 1; fi
	@grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
